/* filelist.f */
common/apb_pkg.sv
common/clint_pkg.sv
hdl/apb_region_decode.sv
hdl/sys_timer.sv
clint/clint_regs.sv
clint/clint_irq.sv
hdl/clint_subsys.sv
testbench/tb_clk_gen.sv
testbench/tb_clint_subsys.sv

/* testbench/tb_clint_subsys.sv */
`default_nettype none

module tb_clint_subsys
    import apb_pkg::*, clint_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam int          clk_period = 20;
localparam int          wait_limit = 2000;
localparam logic [15:0] lfsr_taps  = 16'hB400;

logic                  clk;
logic                  rstn;
logic                  psel;
logic                  penable;
logic                  pwrite;
logic [apb_addr_w-1:0] paddr;
logic [apb_data_w-1:0] pwdata;
logic [apb_data_w-1:0] prdata;
logic                  pready;
logic                  pslverr;
logic [cpu_num-1:0]    msip;
logic [cpu_num-1:0]    mtip;

logic [cpu_num-1:0]    msip_m;
logic [time_w-1:0]     cmp_m [cpu_num];
logic [time_w-1:0]     mtime_m;        // only tracked while the timer is stopped.
logic                  enable_m;
logic [prescale_w-1:0] prescale_m;
logic [cpu_num-1:0]    mtip_exp;

logic                  rd_chk;
logic [apb_data_w-1:0] rd_exp;
logic                  mtip_chk_en;
logic                  hold_en;
logic                  fall_chk;
logic [cpu_num-1:0]    watch_mask;
logic                  delta_chk;
int                    delta_val;
int                    delta_lo;
logic [15:0]           lfsr_q;
int                    err_cnt;
int                    timeout_cnt;
int                    tests_run;
int                    tests_failed;
int                    err_base;

tb_clk_gen #(.period_ns(clk_period), .reset_cycles(10)) u_clk (.clk(clk), .rstn(rstn));

clint_subsys u_dut (
    .clk     (clk),
    .rstn    (rstn),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .msip    (msip),
    .mtip    (mtip)
);

always_comb begin
    for (int i = 0; i < cpu_num; i++) begin
        mtip_exp[i] = (mtime_m >= cmp_m[i]);
    end
end

task automatic note_fail(input string msg);
    $display("FAIL at %0d ns: %s", $time, msg);
    err_cnt++;
endtask

task automatic note_timeout(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
    timeout_cnt++;
endtask

a_bus: assert property (@(posedge clk) disable iff (!rstn) pready && !pslverr)
    else note_fail("pready low or pslverr high");
a_rdata: assert property (@(posedge clk) disable iff (!rstn) rd_chk |-> prdata == rd_exp)
    else note_fail($sformatf("read 0x%04h gave 0x%08h, expected 0x%08h", paddr, prdata, rd_exp));
a_msip: assert property (@(posedge clk) disable iff (!rstn) msip == msip_m)
    else note_fail($sformatf("msip is %b, expected %b", msip, msip_m));
a_mtip_rst: assert property (@(posedge clk) $rose(rstn) |=> mtip == '1)
    else note_fail("mtip not all ones one cycle after reset");
a_mtip_cmp: assert property (@(posedge clk) disable iff (!rstn)
    mtip_chk_en && $past(mtip_chk_en) |-> mtip == $past(mtip_exp))
    else note_fail($sformatf("mtip is %b, expected %b", mtip, $past(mtip_exp)));
a_mtip_hold: assert property (@(posedge clk) disable iff (!rstn)
    hold_en && $past(hold_en) |-> (mtip & ~watch_mask) == ($past(mtip) & ~watch_mask))
    else note_fail("mtip of an unwatched hart changed");
a_mtip_fall: assert property (@(posedge clk) disable iff (!rstn)
    fall_chk |-> (mtip & watch_mask) == '0)
    else note_fail("mtip did not fall within two cycles");
a_delta: assert property (@(posedge clk) delta_chk |-> (delta_val == delta_lo ||
    delta_val == delta_lo + 1))
    else note_fail($sformatf("mtime moved by %0d, expected %0d or one more", delta_val, delta_lo));

// galois lfsr stepped once per bit.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        b;
    val = '0;
    for (int i = 0; i < n; i++) begin
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) lfsr_q = lfsr_q ^ lfsr_taps;
        val = {val[30:0], b};
    end
    return val;
endfunction

function automatic logic [15:0] msip_addr(input int h);
    return clint_msip_base + 16'(4 * h);
endfunction

function automatic logic [15:0] cmp_addr(input int h, input bit hi);
    return clint_timecmp_base + 16'(8 * h + (hi ? 4 : 0));
endfunction

function automatic apb_region_e addr_region(input logic [15:0] addr);
    if (addr == clint_time_addr || addr == clint_time_hi_addr || addr >= 16'hC000) begin
        return region_timer;
    end
    return (addr < 16'h8000) ? region_clint : region_none;
endfunction

function automatic void model_write(input logic [15:0] addr, input logic [31:0] data);
    case (addr_region(addr))
        region_timer: begin
            if (addr == clint_time_addr) mtime_m[31:0] = data;
            if (addr == clint_time_hi_addr) mtime_m[63:32] = data;
            if (addr == timer_ctrl_addr) enable_m = data[0];
            if (addr == timer_prescale_addr) prescale_m = data[15:0];
        end
        region_clint: begin
            for (int h = 0; h < cpu_num; h++) begin
                if (addr == msip_addr(h)) msip_m[h] = data[0];
                if (addr == cmp_addr(h, 0)) cmp_m[h][31:0] = data;
                if (addr == cmp_addr(h, 1)) cmp_m[h][63:32] = data;
            end
        end
        default: ;
    endcase
endfunction

function automatic logic [31:0] model_read(input logic [15:0] addr);
    logic [31:0] val;
    val = '0;
    if (addr_region(addr) == region_timer) begin
        if (addr == clint_time_addr) val = mtime_m[31:0];
        if (addr == clint_time_hi_addr) val = mtime_m[63:32];
        if (addr == timer_ctrl_addr) val = {31'b0, enable_m};
        if (addr == timer_prescale_addr) val = {16'b0, prescale_m};
    end
    else if (addr_region(addr) == region_clint) begin
        for (int h = 0; h < cpu_num; h++) begin
            if (addr == msip_addr(h)) val = {31'b0, msip_m[h]};
            if (addr == cmp_addr(h, 0)) val = cmp_m[h][31:0];
            if (addr == cmp_addr(h, 1)) val = cmp_m[h][63:32];
        end
    end
    return val;
endfunction

task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
        @(negedge clk);
    end
endtask

task automatic wait_ready();
    int n;
    n = 0;
    @(posedge clk);
    while (!pready && n < wait_limit) begin
        @(posedge clk);
        n++;
    end
    if (!pready) note_timeout("APB pready");
endtask

task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    model_write(addr, data);  // committed on the setup edge.
    wait_ready();
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [15:0] addr, input logic chk, output logic [31:0] data,
                        output time t_setup);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    t_setup = $time;
    @(negedge clk);
    penable = 1'b1;
    rd_exp  = model_read(addr);
    rd_chk  = chk;
    wait_ready();
    @(negedge clk);
    data    = prdata;
    rd_chk  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic check_read(input logic [15:0] addr);
    logic [31:0] d;
    time         t;
    apb_read(addr, 1'b1, d, t);
endtask

task automatic check_all_regs();
    for (int h = 0; h < cpu_num; h++) begin
        check_read(msip_addr(h));
        check_read(cmp_addr(h, 0));
        check_read(cmp_addr(h, 1));
    end
    check_read(timer_ctrl_addr);
    check_read(timer_prescale_addr);
endtask

task automatic wait_reset_release();
    int n;
    n = 0;
    while (rstn !== 1'b1 && n < wait_limit) begin
        @(posedge clk);
        n++;
    end
    if (rstn !== 1'b1) note_timeout("reset release");
endtask

task automatic check_reset_state();
    @(negedge clk);
    mtip_chk_en = 1'b1;
    check_all_regs();
    check_read(clint_time_addr);
    check_read(clint_time_hi_addr);
    idle_cycles(20);
    check_read(clint_time_addr);  // timer is stopped.
    check_read(clint_time_hi_addr);
endtask

task automatic soft_irq_walk();
    for (int r = 0; r < 3; r++) begin
        for (int h = 0; h < cpu_num; h++) begin
            apb_write(msip_addr(h), rand_bits(32));
        end
        for (int h = 0; h < cpu_num; h++) begin
            check_read(msip_addr(h));
        end
    end
endtask

task automatic compare_regs_walk();
    for (int h = 0; h < cpu_num; h++) begin
        apb_write(cmp_addr(h, 0), rand_bits(32));
        apb_write(cmp_addr(h, 1), rand_bits(32));
    end
    for (int h = 0; h < cpu_num; h++) begin
        check_read(cmp_addr(h, 0));
        check_read(cmp_addr(h, 1));
    end
    apb_write(cmp_addr(0, 0), 32'h40);
    apb_write(cmp_addr(0, 1), 32'h0);
    for (int i = 0; i < 4; i++) begin
        apb_write(clint_time_addr, rand_bits(8));
        apb_write(clint_time_hi_addr, 32'h0);
        idle_cycles(2);
        check_read(clint_time_addr);
    end
    apb_write(cmp_addr(0, 1), 32'h1);  // hart 0 out of reach again.
    idle_cycles(2);
endtask

task automatic timer_count_check();
    int          p;
    logic [31:0] t1;
    logic [31:0] t2;
    time         s1;
    time         s2;
    mtip_chk_en = 1'b0;
    p = int'(rand_bits(2));
    apb_write(timer_prescale_addr, 32'(p));
    apb_write(clint_time_addr, 32'h0);
    apb_write(clint_time_hi_addr, 32'h0);
    apb_write(timer_ctrl_addr, 32'h1);
    check_read(timer_ctrl_addr);
    check_read(timer_prescale_addr);
    for (int i = 0; i < 4; i++) begin
        apb_read(clint_time_addr, 1'b0, t1, s1);
        idle_cycles(int'(rand_bits(5)) + 1);
        apb_read(clint_time_addr, 1'b0, t2, s2);
        delta_val = int'(t2 - t1);
        delta_lo  = int'((s2 - s1) / clk_period) / (p + 1);
        delta_chk = 1'b1;
        @(negedge clk);
        delta_chk = 1'b0;
    end
endtask

task automatic timer_irq_check();
    int          h;
    int          n;
    logic [31:0] now;
    time         s;
    h = int'(rand_bits(2)) % cpu_num;
    watch_mask = '0;
    watch_mask[h] = 1'b1;
    apb_read(clint_time_addr, 1'b0, now, s);
    hold_en = 1'b1;
    apb_write(cmp_addr(h, 0), now + 32'd16 + rand_bits(4));
    apb_write(cmp_addr(h, 1), 32'h0);
    n = 0;
    while (!mtip[h] && n < wait_limit) begin
        @(negedge clk);
        n++;
    end
    if (!mtip[h]) note_timeout("mtip rise of the watched hart");
    apb_write(cmp_addr(h, 1), 32'hFFFF_FFFF);
    fall_chk = 1'b1;
    @(negedge clk);
    fall_chk = 1'b0;
    idle_cycles(2);
    hold_en = 1'b0;
endtask

task automatic unmapped_access_check();
    check_read(16'h8000);
    check_read(16'hA000);
    apb_write(16'h8000, rand_bits(32));
    apb_write(16'hA000, rand_bits(32));
    check_read(16'h8000);
    check_read(16'hA000);
    check_all_regs();
endtask

task automatic close_test(input string name);
    int fails;
    fails = err_cnt + timeout_cnt - err_base;
    tests_run++;
    if (fails == 0) begin
        $display("test %-12s ok", name);
    end
    else begin
        tests_failed++;
        $display("test %-12s %0d failures", name, fails);
    end
    err_base = err_cnt + timeout_cnt;
endtask

initial begin
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    rd_chk      = 1'b0;
    rd_exp      = '0;
    mtip_chk_en = 1'b0;
    hold_en     = 1'b0;
    fall_chk    = 1'b0;
    watch_mask  = '0;
    delta_chk   = 1'b0;
    delta_val   = 0;
    delta_lo    = 0;
    msip_m      = '0;
    mtime_m     = '0;
    enable_m    = 1'b0;
    prescale_m  = '0;
    for (int i = 0; i < cpu_num; i++) begin
        cmp_m[i] = '0;
    end
    lfsr_q       = 16'd46568;
    err_cnt      = 0;
    timeout_cnt  = 0;
    tests_run    = 0;
    tests_failed = 0;
    err_base     = 0;

    wait_reset_release();
    check_reset_state();
    close_test("reset");
    soft_irq_walk();
    close_test("msip");
    compare_regs_walk();
    close_test("mtimecmp");
    timer_count_check();
    close_test("counting");
    timer_irq_check();
    close_test("timer_irq");
    unmapped_access_check();
    close_test("unmapped");

    $display("tests %0d, passed %0d, failed %0d, errors %0d, timeouts %0d",
             tests_run, tests_run - tests_failed, tests_failed, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
        $display("TB PASSED");
    end
    else begin
        $display("TB FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rstn
);

timeunit 1ns;
timeprecision 100ps;

initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
end

initial begin
    rstn = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;  // released away from the rising edge.
end

endmodule

`default_nettype wire

/* hdl/clint_subsys.sv */
`default_nettype none

module clint_subsys
    import apb_pkg::*, clint_pkg::*;
(
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   psel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  wire  [apb_addr_w-1:0] paddr,
    input  wire  [apb_data_w-1:0] pwdata,

    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic [cpu_num-1:0]    msip,
    output logic [cpu_num-1:0]    mtip
);

logic                           timer_sel;
logic                           clint_sel;
logic [apb_data_w-1:0]          timer_prdata;
logic [apb_data_w-1:0]          clint_prdata;
logic [time_w-1:0]              mtime;
logic [cpu_num-1:0][time_w-1:0] mtimecmp;

apb_region_decode u_decode (
    .clk          (clk),
    .rstn         (rstn),
    .psel         (psel),
    .penable      (penable),
    .paddr        (paddr),
    .timer_prdata (timer_prdata),
    .clint_prdata (clint_prdata),
    .timer_sel    (timer_sel),
    .clint_sel    (clint_sel),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr)
);

sys_timer u_timer (
    .clk     (clk),
    .rstn    (rstn),
    .sel     (timer_sel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (timer_prdata),
    .mtime   (mtime)
);

clint_regs u_regs (
    .clk      (clk),
    .rstn     (rstn),
    .sel      (clint_sel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (clint_prdata),
    .msip     (msip),
    .mtimecmp (mtimecmp)
);

clint_irq u_irq (
    .clk      (clk),
    .rstn     (rstn),
    .mtime    (mtime),
    .mtimecmp (mtimecmp),
    .mtip     (mtip)
);

endmodule

`default_nettype wire

/* clint/clint_irq.sv */
`default_nettype none

module clint_irq
    import clint_pkg::*;
(
    input  wire                            clk,
    input  wire                            rstn,
    input  wire  [time_w-1:0]              mtime,
    input  wire  [cpu_num-1:0][time_w-1:0] mtimecmp,

    output logic [cpu_num-1:0]             mtip
);

logic [cpu_num-1:0] expired;

// unsigned compare per hart.
always_comb begin
    for (int i = 0; i < cpu_num; i++) begin
        expired[i] = (mtime >= mtimecmp[i]);
    end
end

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        mtip <= '0;
    end
    else begin
        mtip <= expired;  // one cycle behind the inputs.
    end
end

endmodule

`default_nettype wire

/* clint/clint_regs.sv */
`default_nettype none

module clint_regs
    import apb_pkg::*, clint_pkg::*;
(
    input  wire                               clk,
    input  wire                               rstn,
    input  wire                               sel,
    input  wire                               penable,
    input  wire                               pwrite,
    input  wire  [apb_addr_w-1:0]             paddr,
    input  wire  [apb_data_w-1:0]             pwdata,

    output logic [apb_data_w-1:0]             prdata,
    output logic [cpu_num-1:0]                msip,
    output logic [cpu_num-1:0][time_w-1:0]    mtimecmp
);

logic                  apb_wr;
logic                  apb_rd;
logic [apb_data_w-1:0] rdata_msip;
logic [apb_data_w-1:0] rdata_timecmp;

assign apb_wr = sel && !penable && pwrite;
assign apb_rd = sel && !penable && !pwrite;

for (genvar g = 0; g < cpu_num; g++) begin : g_hart
    localparam logic [apb_addr_w-1:0] msip_addr = clint_msip_base + apb_addr_w'(4 * g);
    localparam logic [apb_addr_w-1:0] cmp_lo    = clint_timecmp_base + apb_addr_w'(8 * g);
    localparam logic [apb_addr_w-1:0] cmp_hi    = cmp_lo + apb_addr_w'(4);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            msip[g] <= 1'b0;
        end
        else if (apb_wr && paddr == msip_addr) begin
            msip[g] <= pwdata[0];
        end
    end

    // one 32-bit half per write.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mtimecmp[g] <= '0;
        end
        else if (apb_wr && paddr == cmp_lo) begin
            mtimecmp[g][apb_data_w-1:0] <= pwdata;
        end
        else if (apb_wr && paddr == cmp_hi) begin
            mtimecmp[g][time_w-1:apb_data_w] <= pwdata;
        end
    end
end

always_comb begin
    rdata_msip = '0;
    for (int i = 0; i < cpu_num; i++) begin
        rdata_msip = rdata_msip |
                     ({{(apb_data_w-1){1'b0}}, msip[i]} &
                      {apb_data_w{paddr == clint_msip_base + apb_addr_w'(4 * i)}});
    end
end

always_comb begin
    rdata_timecmp = '0;
    for (int i = 0; i < cpu_num; i++) begin
        rdata_timecmp = rdata_timecmp |
                        (mtimecmp[i][apb_data_w-1:0] &
                         {apb_data_w{paddr == clint_timecmp_base + apb_addr_w'(8 * i)}}) |
                        (mtimecmp[i][time_w-1:apb_data_w] &
                         {apb_data_w{paddr == clint_timecmp_base + apb_addr_w'(8 * i + 4)}});
    end
end

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        prdata <= '0;
    end
    else if (apb_rd) begin
        prdata <= rdata_msip | rdata_timecmp;  // windows never overlap.
    end
end

endmodule

`default_nettype wire

/* hdl/sys_timer.sv */
`default_nettype none

module sys_timer
    import apb_pkg::*, clint_pkg::*;
(
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   sel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  wire  [apb_addr_w-1:0] paddr,
    input  wire  [apb_data_w-1:0] pwdata,

    output logic [apb_data_w-1:0] prdata,
    output logic [time_w-1:0]     mtime
);

logic                  apb_wr;
logic                  apb_rd;
logic                  time_wr_lo;
logic                  time_wr_hi;
logic                  enable;
logic [prescale_w-1:0] prescale;
logic [prescale_w-1:0] pcnt;
logic                  tick;
logic [apb_data_w-1:0] rdata;

assign apb_wr = sel && !penable && pwrite;
assign apb_rd = sel && !penable && !pwrite;

assign time_wr_lo = apb_wr && (paddr == clint_time_addr);
assign time_wr_hi = apb_wr && (paddr == clint_time_hi_addr);

// >= so a smaller P written mid-count does not wrap.
assign tick = enable && (pcnt >= prescale);

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        enable   <= 1'b0;
        prescale <= '0;
    end
    else if (apb_wr) begin
        if (paddr == timer_ctrl_addr) begin
            enable <= pwdata[0];
        end
        if (paddr == timer_prescale_addr) begin
            prescale <= pwdata[prescale_w-1:0];
        end
    end
end

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        pcnt <= '0;
    end
    else if (time_wr_lo || time_wr_hi || !enable || tick) begin
        pcnt <= '0;  // mtime write restarts the prescaler.
    end
    else begin
        pcnt <= pcnt + 1'b1;
    end
end

// a write beats the increment.
always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        mtime <= '0;
    end
    else if (time_wr_lo) begin
        mtime[apb_data_w-1:0] <= pwdata;
    end
    else if (time_wr_hi) begin
        mtime[time_w-1:apb_data_w] <= pwdata;
    end
    else if (tick) begin
        mtime <= mtime + 1'b1;
    end
end

always_comb begin
    rdata = '0;
    case (paddr)
        clint_time_addr:     rdata = mtime[apb_data_w-1:0];
        clint_time_hi_addr:  rdata = mtime[time_w-1:apb_data_w];
        timer_ctrl_addr:     rdata[0] = enable;
        timer_prescale_addr: rdata[prescale_w-1:0] = prescale;
        default:             rdata = '0;
    endcase
end

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        prdata <= '0;
    end
    else if (apb_rd) begin
        prdata <= rdata;  // valid in access phase.
    end
end

endmodule

`default_nettype wire

/* hdl/apb_region_decode.sv */
`default_nettype none

module apb_region_decode
    import apb_pkg::*, clint_pkg::*;
(
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   psel,
    input  wire                   penable,
    input  wire  [apb_addr_w-1:0] paddr,
    input  wire  [apb_data_w-1:0] timer_prdata,
    input  wire  [apb_data_w-1:0] clint_prdata,

    output logic                  timer_sel,
    output logic                  clint_sel,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

apb_region_e region;
apb_region_e region_q;

always_comb begin
    if (paddr == clint_time_addr || paddr == clint_time_hi_addr) begin
        region = region_timer;  // mtime sits inside the clint window.
    end
    else if (paddr >= timer_region_base) begin
        region = region_timer;
    end
    else if (paddr < clint_region_limit) begin
        region = region_clint;
    end
    else begin
        region = region_none;
    end
end

assign timer_sel = psel && (region == region_timer);
assign clint_sel = psel && (region == region_clint);

// held from setup so the mux is right during access.
always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        region_q <= region_none;
    end
    else if (psel && !penable) begin
        region_q <= region;
    end
end

always_comb begin
    case (region_q)
        region_timer: prdata = timer_prdata;
        region_clint: prdata = clint_prdata;
        default:      prdata = '0;  // unmapped reads as zero.
    endcase
end

assign pready  = 1'b1;
assign pslverr = 1'b0;

endmodule

`default_nettype wire

/* common/clint_pkg.sv */
`default_nettype none

package clint_pkg;

    localparam int cpu_num = 4;     // up to 64 harts.
    localparam int time_w  = 64;    // mtime and mtimecmp.

    localparam int prescale_w = 16;

    // msip of hart n at base + 4n.
    localparam logic [apb_pkg::apb_addr_w-1:0] clint_msip_base    = 16'h0000;

    // hart n has its mtimecmp low word at base + 8n.
    localparam logic [apb_pkg::apb_addr_w-1:0] clint_timecmp_base = 16'h4000;

    localparam logic [apb_pkg::apb_addr_w-1:0] clint_time_addr    = 16'hBFF8;
    localparam logic [apb_pkg::apb_addr_w-1:0] clint_time_hi_addr = 16'hBFFC;

    // bit 0 of timer control enables counting.
    localparam logic [apb_pkg::apb_addr_w-1:0] timer_ctrl_addr     = 16'hC000;

    // mtime advances every P+1 cycles.
    localparam logic [apb_pkg::apb_addr_w-1:0] timer_prescale_addr = 16'hC004;

    // region boundaries for the decoder.
    localparam logic [apb_pkg::apb_addr_w-1:0] clint_region_limit = 16'h8000;
    localparam logic [apb_pkg::apb_addr_w-1:0] timer_region_base  = 16'hC000;

endpackage

`default_nettype wire

/* common/apb_pkg.sv */
`default_nettype none

package apb_pkg;

    // bus widths of the slave port.
    localparam int apb_addr_w = 16;
    localparam int apb_data_w = 32;

    // which block an APB address belongs to.
    typedef enum logic [1:0] {
        region_clint = 2'd0,
        region_timer = 2'd1,
        region_none  = 2'd2
    } apb_region_e;

endpackage

`default_nettype wire
